/* all.f */
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/register_file.sv
source/execute_unit.sv
source/core_top.sv
verif/core_assertions.sv
verif/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f all.f --top-module core_tb --Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/core_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Checks failed" "$log"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation passed"
exit 0

/* verif/core_tb.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb;

  localparam int NUM_RETIRE      = 400;
  localparam int WATCHDOG_CYCLES = NUM_RETIRE * 12;  // Worst case per retirement, with margin
  localparam int PROG_WORDS      = 64;
  localparam logic [`XLEN-1:0] PROG_END = `XLEN'(PROG_WORDS * 4);  // First byte past the program

  // Instruction kinds drawn by the generator
  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_ADDI = 5;
  localparam int K_JAL  = 6;
  localparam int K_BEQ  = 7;

  // addi x0,x0,0
  localparam logic [`INSTR_W-1:0] NOP_WORD =
    {12'd0, 5'd0, isa_pkg::F3_ADD_SUB, 5'd0, isa_pkg::OP_IMM};

  logic                   clk = 1'b0;
  logic                   reset = 1'b1;        // Held from time zero
  logic                   imem_req;
  logic [`XLEN-1:0]       imem_addr;
  logic                   imem_valid = 1'b0;
  logic [`INSTR_W-1:0]    imem_data = '0;
  logic                   retire_valid;
  logic [`XLEN-1:0]       retire_pc;
  logic [`REG_ADDR_W-1:0] retire_rd;
  logic                   retire_we;
  logic [`XLEN-1:0]       retire_data;

  logic [31:0]            lfsr = 32'h1b10;

  // Generated program, one entry per word
  int                     prog_kind [PROG_WORDS];
  logic [`REG_ADDR_W-1:0] prog_rd   [PROG_WORDS];
  logic [`REG_ADDR_W-1:0] prog_rs1  [PROG_WORDS];
  logic [`REG_ADDR_W-1:0] prog_rs2  [PROG_WORDS];
  logic [`XLEN-1:0]       prog_imm  [PROG_WORDS];  // addi immediate or byte offset
  logic [`INSTR_W-1:0]    prog_word [PROG_WORDS];

  // ISA model and the expected retire values
  logic [`XLEN-1:0]       model_regs [`REG_COUNT] = '{default: '0};
  logic [`XLEN-1:0]       model_pc = `RESET_PC;
  logic [`XLEN-1:0]       exp_pc;
  logic [`XLEN-1:0]       exp_data;
  logic [`REG_ADDR_W-1:0] exp_rd;
  logic                   exp_we;
  int                     exp_kind;
  int                     retired = 0;

  // Memory model latency state
  int                     wait_left = 0;
  logic                   wait_armed = 1'b0;
  logic                   seen_req = 1'b0;    // First request after reset not yet seen

  core_top uut (
    .clk(clk), .reset(reset),
    .imem_req(imem_req), .imem_addr(imem_addr),
    .imem_valid(imem_valid), .imem_data(imem_data),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_we(retire_we), .retire_data(retire_data)
  );

  bind core_top core_assertions u_checks (
    .clk(clk), .reset(reset),
    .imem_req(imem_req), .imem_valid(imem_valid), .imem_addr(imem_addr),
    .retire_valid(retire_valid), .retire_we(retire_we), .retire_rd(retire_rd)
  );

  always #5 clk = ~clk;                         // 10 ns period

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Program occupies bytes 0 to 255, filler beyond
  function automatic logic [`INSTR_W-1:0] fetch_word(input logic [`XLEN-1:0] addr);
    if (addr < PROG_END) return prog_word[addr[7:2]];
    return NOP_WORD;
  endfunction

  task automatic build_program();
    logic [31:0]            r;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    for (int i = 0; i < PROG_WORDS; i++) begin
      r            = take_bits(3);
      prog_kind[i] = int'(r);
      r   = take_bits(3);
      rd  = r[`REG_ADDR_W-1:0];                 // x0 to x7 only
      r   = take_bits(3);
      rs1 = r[`REG_ADDR_W-1:0];
      r   = take_bits(3);
      rs2 = r[`REG_ADDR_W-1:0];
      imm = '0;
      if (prog_kind[i] == K_ADDI) begin
        r   = take_bits(12);
        imm = {{(`XLEN-12){r[11]}}, r[11:0]};
      end else if (prog_kind[i] == K_JAL || prog_kind[i] == K_BEQ) begin
        r   = take_bits(2);
        imm = (`XLEN'(r[1:0]) + `XLEN'd1) << 2;  // 1 to 4 words ahead
      end
      case (prog_kind[i])
        K_ADD:  prog_word[i] = {7'd0, rs2, rs1, isa_pkg::F3_ADD_SUB, rd, isa_pkg::OP_REG};
        K_SUB:  prog_word[i] = {isa_pkg::F7_SUB, rs2, rs1, isa_pkg::F3_ADD_SUB, rd,
                                isa_pkg::OP_REG};
        K_AND:  prog_word[i] = {7'd0, rs2, rs1, isa_pkg::F3_AND, rd, isa_pkg::OP_REG};
        K_OR:   prog_word[i] = {7'd0, rs2, rs1, isa_pkg::F3_OR, rd, isa_pkg::OP_REG};
        K_XOR:  prog_word[i] = {7'd0, rs2, rs1, isa_pkg::F3_XOR, rd, isa_pkg::OP_REG};
        K_ADDI: prog_word[i] = {imm[11:0], rs1, isa_pkg::F3_ADD_SUB, rd, isa_pkg::OP_IMM};
        K_JAL:  prog_word[i] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::OP_JAL};
        default: prog_word[i] = {imm[12], imm[10:5], rs2, rs1, isa_pkg::F3_BEQ, imm[4:1],
                                 imm[11], isa_pkg::OP_BRANCH};  // beq
      endcase
      prog_rd[i]  = rd;
      prog_rs1[i] = rs1;
      prog_rs2[i] = rs2;
      prog_imm[i] = imm;
    end
  endtask

  // Executes the instruction at model_pc
  task automatic model_step(output logic [`XLEN-1:0] pc, output logic [`REG_ADDR_W-1:0] rd,
                            output logic we, output logic [`XLEN-1:0] data, output int kind);
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       a;
    logic [`XLEN-1:0]       b;
    logic [`XLEN-1:0]       next_pc;
    pc = model_pc;
    if (model_pc < PROG_END) begin
      kind = prog_kind[model_pc[7:2]];
      rd   = prog_rd[model_pc[7:2]];
      rs1  = prog_rs1[model_pc[7:2]];
      rs2  = prog_rs2[model_pc[7:2]];
      imm  = prog_imm[model_pc[7:2]];
    end else begin
      kind = K_ADDI;                            // Filler nop
      rd   = '0;
      rs1  = '0;
      rs2  = '0;
      imm  = '0;
    end
    a       = model_regs[rs1];                  // x0 is never written, stays zero
    b       = model_regs[rs2];
    next_pc = pc + `XLEN'd4;
    data    = '0;
    case (kind)
      K_ADD:  data = a + b;
      K_SUB:  data = a - b;
      K_AND:  data = a & b;
      K_OR:   data = a | b;
      K_XOR:  data = a ^ b;
      K_ADDI: data = a + imm;
      K_JAL: begin
        data    = pc + `XLEN'd4;                // Link address
        next_pc = pc + imm;
      end
      default: if (a == b) next_pc = pc + imm;  // beq
    endcase
    we = (kind != K_BEQ) && (rd != '0);
    if (we) model_regs[rd] = data;
    model_pc = next_pc;
  endtask

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic word_check(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic index_check(input string name, input logic [`REG_ADDR_W-1:0] got,
                             input logic [`REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is x%0d, expected x%0d", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // Memory model, 0 to 3 extra cycles per request
  always @(negedge clk) begin
    imem_valid <= 1'b0;
    if (!reset && imem_req) begin
      if (!seen_req) begin
        word_check("imem_addr", imem_addr, `RESET_PC);
        seen_req = 1'b1;
      end
      if (!wait_armed) begin
        wait_left  = int'(take_bits(2));
        wait_armed = 1'b1;
      end
      if (wait_left == 0) begin
        imem_valid <= 1'b1;
        imem_data  <= fetch_word(imem_addr);
        wait_armed = 1'b0;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // Retire monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && retire_valid) begin
      model_step(exp_pc, exp_rd, exp_we, exp_data, exp_kind);
      word_check("retire_pc", retire_pc, exp_pc);
      flag_check("retire_we", retire_we, exp_we);
      if (exp_kind != K_BEQ) begin              // beq carries no result
        index_check("retire_rd", retire_rd, exp_rd);
        word_check("retire_data", retire_data, exp_data);
      end
      retired = retired + 1;
    end
  end

  initial begin
    build_program();
    repeat (5) begin                            // Five reset cycles
      @(posedge clk);
      @(negedge clk);
      flag_check("imem_req", imem_req, 1'b0);
      flag_check("retire_valid", retire_valid, 1'b0);
    end
    reset <= 1'b0;
    wait (retired == NUM_RETIRE);
    $display("All checks passed");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: only %0d of %0d instructions retired", retired, NUM_RETIRE);
    stop_on_failure();
  end

endmodule

/* verif/core_assertions.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_assertions (
  input logic                   clk,
  input logic                   reset,
  input logic                   imem_req,
  input logic                   imem_valid,
  input logic [`XLEN-1:0]       imem_addr,
  input logic                   retire_valid,
  input logic                   retire_we,
  input logic [`REG_ADDR_W-1:0] retire_rd
);

  // Outstanding request holds its address until the strobe
  property addr_held_p;
    @(posedge clk) disable iff (reset)
      (imem_req && !imem_valid) |=> $stable(imem_addr);
  endproperty

  addr_held_a: assert property (addr_held_p)
    else $error("imem_addr moved while a request was outstanding");

  // x0 is never reported as written
  no_x0_write_a: assert property (@(posedge clk) disable iff (reset)
                                  !(retire_we && retire_rd == '0))
    else $error("retire_we high with retire_rd x0");

  // Quiet retire port while in reset
  reset_quiet_a: assert property (@(posedge clk) reset |=> !retire_valid)
    else $error("retire_valid high during reset");

endmodule

/* source/core_top.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top (
  input  logic                   clk,
  input  logic                   reset,
  output logic                   imem_req,
  output logic [`XLEN-1:0]       imem_addr,
  input  logic                   imem_valid,
  input  logic [`INSTR_W-1:0]    imem_data,
  output logic                   retire_valid,
  output logic [`XLEN-1:0]       retire_pc,
  output logic [`REG_ADDR_W-1:0] retire_rd,
  output logic                   retire_we,
  output logic [`XLEN-1:0]       retire_data
);

  // IF/ID
  logic                          if_valid;
  isa_pkg::instr_t               if_instr;
  logic [`XLEN-1:0]              if_pc;
  logic                          if_take;

  // Register file read side
  logic [`REG_ADDR_W-1:0]        rs1_addr;
  logic [`REG_ADDR_W-1:0]        rs2_addr;
  logic [`XLEN-1:0]              rs1_data;
  logic [`XLEN-1:0]              rs2_data;

  // ID/EX
  logic                          id_valid;
  logic [`XLEN-1:0]              id_pc;
  logic [`XLEN-1:0]              id_rs1_data;
  logic [`XLEN-1:0]              id_rs2_data;
  logic [`XLEN-1:0]              id_imm;
  logic [`REG_ADDR_W-1:0]        id_rd;
  logic                          id_we;
  logic [core_pkg::ALU_OP_W-1:0] id_alu_op;
  logic                          id_use_imm;
  logic [core_pkg::BR_W-1:0]     id_branch;

  // Control flow and writeback
  logic                          redirect;
  logic [`XLEN-1:0]              redirect_pc;
  logic                          wb_we;
  logic [`REG_ADDR_W-1:0]        wb_rd;
  logic [`XLEN-1:0]              wb_data;

  fetch_unit u_fetch (
    .clk(clk), .reset(reset),
    .imem_valid(imem_valid), .imem_data(imem_data),
    .if_take(if_take), .redirect(redirect), .redirect_pc(redirect_pc),
    .imem_req(imem_req), .imem_addr(imem_addr),
    .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc)
  );

  decode_unit u_decode (
    .clk(clk), .reset(reset),
    .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .redirect(redirect),
    .wb_we(wb_we), .wb_rd(wb_rd),
    .if_take(if_take), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .id_valid(id_valid), .id_pc(id_pc), .id_rs1_data(id_rs1_data),
    .id_rs2_data(id_rs2_data), .id_imm(id_imm), .id_rd(id_rd), .id_we(id_we),
    .id_alu_op(id_alu_op), .id_use_imm(id_use_imm), .id_branch(id_branch)
  );

  register_file u_regs (
    .clk(clk), .reset(reset),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  execute_unit u_execute (
    .clk(clk), .reset(reset),
    .id_valid(id_valid), .id_pc(id_pc), .id_rs1_data(id_rs1_data),
    .id_rs2_data(id_rs2_data), .id_imm(id_imm), .id_rd(id_rd), .id_we(id_we),
    .id_alu_op(id_alu_op), .id_use_imm(id_use_imm), .id_branch(id_branch),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_we(retire_we), .retire_data(retire_data)
  );

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          id_valid,
  input  logic [`XLEN-1:0]              id_pc,
  input  logic [`XLEN-1:0]              id_rs1_data,
  input  logic [`XLEN-1:0]              id_rs2_data,
  input  logic [`XLEN-1:0]              id_imm,
  input  logic [`REG_ADDR_W-1:0]        id_rd,
  input  logic                          id_we,
  input  logic [core_pkg::ALU_OP_W-1:0] id_alu_op,
  input  logic                          id_use_imm,
  input  logic [core_pkg::BR_W-1:0]     id_branch,
  output logic                          redirect,
  output logic [`XLEN-1:0]              redirect_pc,
  output logic                          wb_we,
  output logic [`REG_ADDR_W-1:0]        wb_rd,
  output logic [`XLEN-1:0]              wb_data,
  output logic                          retire_valid,
  output logic [`XLEN-1:0]              retire_pc,
  output logic [`REG_ADDR_W-1:0]        retire_rd,
  output logic                          retire_we,
  output logic [`XLEN-1:0]              retire_data
);

  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] result;
  logic             taken;
  logic             we_q;       // Write enable held in the writeback register
  logic [`XLEN-1:0] data_q;
  logic [`REG_ADDR_W-1:0] rd_q;

  assign op_b = id_use_imm ? id_imm : id_rs2_data;

  always_comb begin
    case (id_alu_op)
      core_pkg::ALU_SUB: alu_result = id_rs1_data - op_b;
      core_pkg::ALU_AND: alu_result = id_rs1_data & op_b;
      core_pkg::ALU_OR:  alu_result = id_rs1_data | op_b;
      core_pkg::ALU_XOR: alu_result = id_rs1_data ^ op_b;
      default:           alu_result = id_rs1_data + op_b;  // ALU_ADD
    endcase
  end

  // jal always redirects, beq on equal operands
  always_comb begin
    case (id_branch)
      core_pkg::BR_JAL: taken = 1'b1;
      core_pkg::BR_BEQ: taken = (id_rs1_data == id_rs2_data);
      default:          taken = 1'b0;
    endcase
  end

  assign redirect    = id_valid && taken;      // One cycle, ID/EX empties behind it
  assign redirect_pc = id_pc + id_imm;

  // Link address for jal
  assign result = (id_branch == core_pkg::BR_JAL) ? id_pc + `XLEN'd4 : alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      we_q         <= 1'b0;
    end else begin
      retire_valid <= id_valid;
      we_q         <= id_valid && id_we;       // beq and rd zero never write
    end
  end

  // Writeback payload
  always_ff @(posedge clk) begin
    if (id_valid) begin
      retire_pc <= id_pc;
      rd_q      <= id_rd;
      data_q    <= result;
    end
  end

  // Same register feeds the file and the retire port
  assign wb_we       = we_q;
  assign wb_rd       = rd_q;
  assign wb_data     = data_q;
  assign retire_we   = we_q;
  assign retire_rd   = rd_q;
  assign retire_data = data_q;

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic                   wb_we,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`XLEN-1:0]       wb_data,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Asynchronous reads, x0 hard-wired
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* source/decode_unit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          if_valid,
  input  isa_pkg::instr_t               if_instr,
  input  logic [`XLEN-1:0]              if_pc,
  input  logic [`XLEN-1:0]              rs1_data,
  input  logic [`XLEN-1:0]              rs2_data,
  input  logic                          redirect,
  input  logic                          wb_we,
  input  logic [`REG_ADDR_W-1:0]        wb_rd,
  output logic                          if_take,
  output logic [`REG_ADDR_W-1:0]        rs1_addr,
  output logic [`REG_ADDR_W-1:0]        rs2_addr,
  output logic                          id_valid,
  output logic [`XLEN-1:0]              id_pc,
  output logic [`XLEN-1:0]              id_rs1_data,
  output logic [`XLEN-1:0]              id_rs2_data,
  output logic [`XLEN-1:0]              id_imm,
  output logic [`REG_ADDR_W-1:0]        id_rd,
  output logic                          id_we,
  output logic [core_pkg::ALU_OP_W-1:0] id_alu_op,
  output logic                          id_use_imm,
  output logic [core_pkg::BR_W-1:0]     id_branch
);

  logic [`REG_COUNT-1:0]         busy;  // Pending write per register
  logic [`REG_ADDR_W-1:0]        rd;
  logic                          use_rs1;
  logic                          use_rs2;
  logic                          dec_we;
  logic                          use_imm;
  logic [`XLEN-1:0]              imm;
  logic [core_pkg::ALU_OP_W-1:0] alu_op;
  logic [core_pkg::BR_W-1:0]     branch;
  logic                          stall;
  logic                          issue;

  // Register fields sit in the same place in every kept format
  assign rs1_addr = if_instr.r.rs1;
  assign rs2_addr = if_instr.r.rs2;
  assign rd       = if_instr.r.rd;

  always_comb begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    dec_we  = 1'b0;
    use_imm = 1'b0;
    imm     = '0;
    alu_op  = core_pkg::ALU_ADD;
    branch  = core_pkg::BR_NONE;
    case (if_instr.r.opcode)
      isa_pkg::OP_REG: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        dec_we  = 1'b1;
        case (if_instr.r.funct3)
          isa_pkg::F3_ADD_SUB: alu_op = (if_instr.r.funct7 == isa_pkg::F7_SUB) ?
                                        core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          isa_pkg::F3_XOR:     alu_op = core_pkg::ALU_XOR;
          isa_pkg::F3_OR:      alu_op = core_pkg::ALU_OR;
          isa_pkg::F3_AND:     alu_op = core_pkg::ALU_AND;
          default:             dec_we = 1'b0;  // Not in the subset
        endcase
      end
      isa_pkg::OP_IMM: begin                   // addi only, I view
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        dec_we  = (if_instr.i.funct3 == isa_pkg::F3_ADD_SUB);
        imm     = {{(`XLEN-12){if_instr.i.imm12[11]}}, if_instr.i.imm12};
      end
      isa_pkg::OP_JAL: begin
        dec_we = 1'b1;                         // Link register
        branch = core_pkg::BR_JAL;
        imm    = {{(`XLEN-21){if_instr[31]}}, if_instr[31], if_instr[19:12],
                  if_instr[20], if_instr[30:21], 1'b0};
      end
      isa_pkg::OP_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        branch  = (if_instr.r.funct3 == isa_pkg::F3_BEQ) ? core_pkg::BR_BEQ : core_pkg::BR_NONE;
        imm     = {{(`XLEN-13){if_instr[31]}}, if_instr[31], if_instr[7],
                   if_instr[30:25], if_instr[11:8], 1'b0};
      end
      default: ;                               // Anything else runs as a nop
    endcase
    if (rd == '0) dec_we = 1'b0;               // x0 writes dropped here
  end

  // Wait for older writers of our sources
  assign stall   = (use_rs1 && busy[rs1_addr]) || (use_rs2 && busy[rs2_addr]);
  assign issue   = if_valid && !stall && !redirect;
  assign if_take = issue;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= '0;
      id_valid <= 1'b0;
    end else begin
      id_valid <= issue;                       // Also drops the slot on redirect
      if (wb_we) busy[wb_rd] <= 1'b0;          // Value is in the file after this edge
      if (issue && dec_we) busy[rd] <= 1'b1;   // Newer writer wins over the clear
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    if (issue) begin
      id_pc       <= if_pc;
      id_rs1_data <= rs1_data;
      id_rs2_data <= rs2_data;
      id_imm      <= imm;
      id_rd       <= rd;
      id_we       <= dec_we;
      id_alu_op   <= alu_op;
      id_use_imm  <= use_imm;
      id_branch   <= branch;
    end
  end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                imem_valid,
  input  logic [`INSTR_W-1:0] imem_data,
  input  logic                if_take,
  input  logic                redirect,
  input  logic [`XLEN-1:0]    redirect_pc,
  output logic                imem_req,
  output logic [`XLEN-1:0]    imem_addr,
  output logic                if_valid,
  output isa_pkg::instr_t     if_instr,
  output logic [`XLEN-1:0]    if_pc
);

  logic [`XLEN-1:0] pc;        // Next address to request
  logic [`XLEN-1:0] pc_next;
  logic             stale;     // Outstanding request belongs to a flushed path
  logic             done;      // Request completes on this edge
  logic             accept;    // Response goes into IF/ID
  logic             if_valid_next;
  logic             issue;

  assign done   = imem_req && imem_valid;
  assign accept = done && !stale && !redirect;  // Wrong-path words are dropped

  // IF/ID occupancy after this edge
  always_comb begin
    if_valid_next = if_valid;
    if (redirect) begin
      if_valid_next = 1'b0;                     // Flush
    end else if (accept) begin
      if_valid_next = 1'b1;
    end else if (if_take) begin
      if_valid_next = 1'b0;
    end
  end

  always_comb begin
    pc_next = pc;
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (accept) begin
      pc_next = imem_addr + `XLEN'd4;           // Sequential fetch
    end
  end

  // Start a request only with the port idle and room in IF/ID
  assign issue = (!imem_req || done) && !if_valid_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= `RESET_PC;
      imem_addr <= `RESET_PC;
      imem_req  <= 1'b0;
      stale     <= 1'b0;
      if_valid  <= 1'b0;
    end else begin
      pc       <= pc_next;
      if_valid <= if_valid_next;
      if (issue) begin
        imem_req  <= 1'b1;
        imem_addr <= pc_next;                   // Held until the strobe
      end else if (done) begin
        imem_req  <= 1'b0;
      end
      // Request still in flight keeps or gains the stale mark
      if (imem_req && !imem_valid) begin
        stale <= stale || redirect;
      end else begin
        stale <= 1'b0;
      end
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (accept) begin
      if_instr <= imem_data;
      if_pc    <= imem_addr;
    end
  end

endmodule

/* source/core_pkg.sv */
package core_pkg;

  // Field widths of the internal codes
  localparam int ALU_OP_W = 3;
  localparam int BR_W     = 2;

  // ALU operations chosen in decode
  localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;

  // Control flow kind, resolved in execute
  localparam logic [BR_W-1:0] BR_NONE = 2'd0;  // Falls through
  localparam logic [BR_W-1:0] BR_JAL  = 2'd1;  // Always taken, links pc+4
  localparam logic [BR_W-1:0] BR_BEQ  = 2'd2;  // Taken when rs1 == rs2

endpackage

/* source/isa_pkg.sv */
package isa_pkg;

  // One instruction word, two ways to slice it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;                      // Register-register view
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;                      // Immediate view
  } instr_t;

  // Major opcodes
  localparam logic [6:0] OP_REG    = 7'b0110011;  // add, sub, and, or, xor
  localparam logic [6:0] OP_IMM    = 7'b0010011;  // addi
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq only

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;

  // funct7 that turns add into sub
  localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

/* source/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and address width
`define XLEN 64

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// Fixed 32-bit encodings only, no compressed set
`define INSTR_W 32

// First fetch address out of reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif
